// ==== vlog.f ====
+incdir+rtl
rtl/buf_types_pkg.sv
rtl/buf_regs_pkg.sv
rtl/ring_buffer.sv
rtl/ram_arbiter.sv
rtl/shared_ram.sv
rtl/buffer_irq_regs.sv
rtl/buffer_subsystem.sv
tests/buffer_assertions.sv
tests/buffer_checker.sv
tests/tb_buffer_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_buffer_subsystem
FILELIST  = vlog.f
OBJDIR    = obj_dir
SIMARGS   = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== tests/tb_buffer_subsystem.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module tb_buffer_subsystem;

	localparam int TIMEOUT = 200;

	localparam logic [2:0] OP_IDLE   = 3'd0;
	localparam logic [2:0] OP_DATA   = 3'd1;	// Strobes on all buffers named in the masks
	localparam logic [2:0] OP_REG_WR = 3'd2;
	localparam logic [2:0] OP_REG_RD = 3'd3;
	localparam logic [2:0] OP_PIN    = 3'd4;
	localparam logic [2:0] OP_END    = 3'd5;

	localparam logic [3:0] PIN_IRQ   = 4'd0;
	localparam logic [3:0] PIN_WARN  = 4'd1;
	localparam logic [3:0] PIN_AVAIL = 4'd2;

	typedef struct packed {
		logic [2:0]  op;
		logic [2:0]  wr_mask;
		logic [2:0]  rd_mask;
		logic [3:0]  addr;
		logic [15:0] data;
		logic [15:0] exp;
	} row_t;

	logic                       clk;
	logic                       rst;
	buf_types_pkg::buf_wr_t     wr_drv [`BUF_COUNT];
	logic [`BUF_COUNT-1:0]      rd_drv;
	buf_types_pkg::buf_rd_rsp_t rsp [`BUF_COUNT];
	buf_types_pkg::reg_req_t    reg_drv;
	buf_types_pkg::reg_data_t   reg_rdata;
	buf_types_pkg::reg_data_t   reg_exp;
	logic                       interrupt;
	logic                       fill_warning;
	logic [1:0]                 data_available;
	logic                       pin_chk;
	logic [1:0]                 pin_sel;
	logic [1:0]                 pin_exp;
	logic                       test_end;
	logic [7:0]                 test_num;
	logic                       final_chk;
	int                         errors;
	int                         pending;
	row_t                       table_q [$];
	integer                     seed;
	logic                       timed_out;

	always #20 clk = ~clk;

	buffer_subsystem dut (
		.i_clk            (clk),
		.i_rst            (rst),
		.i_cmd_wr         (wr_drv[0]),
		.i_ch1_wr         (wr_drv[1]),
		.i_ch2_wr         (wr_drv[2]),
		.i_cmd_rd         (rd_drv[0]),
		.i_ch1_rd         (rd_drv[1]),
		.i_ch2_rd         (rd_drv[2]),
		.o_cmd_rd         (rsp[0]),
		.o_ch1_rd         (rsp[1]),
		.o_ch2_rd         (rsp[2]),
		.i_reg            (reg_drv),
		.o_reg_rdata      (reg_rdata),
		.o_interrupt      (interrupt),
		.o_fill_warning   (fill_warning),
		.o_data_available (data_available)
	);

	buffer_checker u_buffer_checker (
		.i_clk            (clk),
		.i_rst            (rst),
		.i_wr             (wr_drv),
		.i_rd             (rd_drv),
		.i_rsp            (rsp),
		.i_reg            (reg_drv),
		.i_reg_rdata      (reg_rdata),
		.i_reg_exp        (reg_exp),
		.i_interrupt      (interrupt),
		.i_fill_warning   (fill_warning),
		.i_data_available (data_available),
		.i_pin_chk        (pin_chk),
		.i_pin_sel        (pin_sel),
		.i_pin_exp        (pin_exp),
		.i_test_end       (test_end),
		.i_test_num       (test_num),
		.i_final          (final_chk),
		.o_errors         (errors),
		.o_pending        (pending)
	);

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [1:0] pin_value(input logic [3:0] sel);
		case (sel)
			PIN_IRQ:  return {1'b0, interrupt};
			PIN_WARN: return {1'b0, fill_warning};
			default:  return data_available;
		endcase
	endfunction

	task automatic add_row(input logic [2:0] op, input logic [2:0] wr_mask,
		input logic [2:0] rd_mask, input logic [3:0] addr, input logic [15:0] data,
		input logic [15:0] exp);
		table_q.push_back(row_t'{op, wr_mask, rd_mask, addr, data, exp});
	endtask

	//////////////////////////////
	// Stimulus table

	task automatic build_table();
		// Reset state, then FIFO order with all three buffers fighting for the RAM
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_WARN, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_IRQ, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::IRQ_MASK, 16'h0, 16'h0000);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT0, 16'h0, 16'h0000);
		add_row(OP_DATA, 3'b111, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b111, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b111, 3'b111, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b011, 3'b110, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b000, 3'b111, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b000, 3'b111, 4'd0, 16'h0, 16'h0);	// Buffer 2 already empty
		add_row(OP_DATA, 3'b000, 3'b001, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h0);
		add_row(OP_END, 3'b000, 3'b000, 4'd0, 16'd1, 16'h0);

		// Count and fill warning on buffer 1
		repeat (6) add_row(OP_DATA, 3'b010, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT1, 16'h0, 16'h0006);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::FILL_WARN, 16'h0, 16'h0002);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_WARN, 16'h0, 16'h1);
		add_row(OP_DATA, 3'b000, 3'b010, 4'd0, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT1, 16'h0, 16'h0005);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::FILL_WARN, 16'h0, 16'h0000);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_WARN, 16'h0, 16'h0);
		repeat (5) add_row(OP_DATA, 3'b000, 3'b010, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h0);
		add_row(OP_END, 3'b000, 3'b000, 4'd0, 16'd2, 16'h0);

		// Full interrupt on the command buffer
		repeat (8) add_row(OP_DATA, 3'b001, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::IRQ_STAT, 16'h0, 16'h0001);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT0, 16'h0, 16'h0008);
		add_row(OP_IDLE, 3'b000, 3'b000, 4'd0, 16'h0, 16'h0);	// Masked status has had time to reach the pin
		add_row(OP_PIN, 3'b000, 3'b000, PIN_IRQ, 16'h0, 16'h0);
		add_row(OP_REG_WR, 3'b000, 3'b000, buf_regs_pkg::IRQ_MASK, 16'h0001, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_IRQ, 16'h0, 16'h1);
		add_row(OP_END, 3'b000, 3'b000, 4'd0, 16'd3, 16'h0);

		// A write while full is dropped, then drain and clear the interrupt
		add_row(OP_DATA, 3'b001, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT0, 16'h0, 16'h0008);
		repeat (9) add_row(OP_DATA, 3'b000, 3'b001, 4'd0, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::COUNT0, 16'h0, 16'h0000);
		add_row(OP_REG_WR, 3'b000, 3'b000, buf_regs_pkg::IRQ_STAT, 16'h0001, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_IRQ, 16'h0, 16'h0);
		add_row(OP_REG_RD, 3'b000, 3'b000, buf_regs_pkg::IRQ_STAT, 16'h0, 16'h0000);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_WARN, 16'h0, 16'h0);
		add_row(OP_END, 3'b000, 3'b000, 4'd0, 16'd4, 16'h0);

		// Data available follows the two sensor buffers
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b000, 3'b110, 4'd0, 16'h0, 16'h0);
		add_row(OP_DATA, 3'b010, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h1);
		add_row(OP_DATA, 3'b100, 3'b000, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h3);
		add_row(OP_DATA, 3'b000, 3'b010, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h2);
		add_row(OP_DATA, 3'b000, 3'b100, 4'd0, 16'h0, 16'h0);
		add_row(OP_PIN, 3'b000, 3'b000, PIN_AVAIL, 16'h0, 16'h0);
		add_row(OP_END, 3'b000, 3'b000, 4'd0, 16'd5, 16'h0);
	endtask

	//////////////////////////////
	// Row driver

	task automatic apply_row(input row_t r);
		logic [31:0] rnd;
		int          wait_cnt;
		case (r.op)
			OP_DATA: begin
				for (int i = 0; i < `BUF_COUNT; i++) begin
					rnd            = $random(seed);
					wr_drv[i].wr   = r.wr_mask[i];
					wr_drv[i].data = rnd[15:0];
				end
				rd_drv = r.rd_mask;
				next_cycle();
				for (int i = 0; i < `BUF_COUNT; i++) begin
					wr_drv[i].wr = 1'b0;
				end
				rd_drv   = '0;
				wait_cnt = 0;
				while (pending != 0 && wait_cnt < TIMEOUT) begin
					next_cycle();
					wait_cnt++;
				end
				if (pending != 0) begin
					$display("Timed out waiting for read data from the buffers");
					timed_out = 1'b1;
				end
				repeat (`BUF_COUNT + 1) next_cycle();	// Leftover writes get one grant per cycle
			end
			OP_REG_WR: begin
				reg_drv.addr  = r.addr;
				reg_drv.wdata = r.data;
				reg_drv.wr    = 1'b1;
				next_cycle();
				reg_drv.wr = 1'b0;
			end
			OP_REG_RD: begin
				reg_drv.addr = r.addr;
				reg_drv.rd   = 1'b1;
				reg_exp      = r.exp;
				next_cycle();
				reg_drv.rd = 1'b0;
				next_cycle();
			end
			OP_PIN: begin
				wait_cnt = 0;
				while (pin_value(r.addr) != r.exp[1:0] && wait_cnt < TIMEOUT) begin
					next_cycle();
					wait_cnt++;
				end
				pin_sel = r.addr[1:0];
				pin_exp = r.exp[1:0];
				pin_chk = 1'b1;
				next_cycle();
				pin_chk = 1'b0;
			end
			OP_END: begin
				test_num = r.data[7:0];
				test_end = 1'b1;
				next_cycle();
				test_end = 1'b0;
			end
			default: next_cycle();
		endcase
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		for (int i = 0; i < `BUF_COUNT; i++) begin
			wr_drv[i] = '0;
		end
		rd_drv    = '0;
		reg_drv   = '0;
		reg_exp   = '0;
		pin_chk   = 1'b0;
		pin_sel   = '0;
		pin_exp   = '0;
		test_end  = 1'b0;
		test_num  = '0;
		final_chk = 1'b0;
		timed_out = 1'b0;
		seed      = 32'h8788ea2c;
		build_table();

		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		foreach (table_q[n]) begin
			if (!timed_out) begin
				apply_row(table_q[n]);
			end
		end

		final_chk = 1'b1;
		next_cycle();
		final_chk = 1'b0;
		next_cycle();

		if (timed_out || errors != 0 ||
			dut.u_ram_arbiter.u_buffer_assertions.fail_count != 0) begin
			$display("** FAIL **");
		end else begin
			$display("** PASS **");
		end
		$finish;
	end

endmodule

// ==== tests/buffer_checker.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module buffer_checker (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  buf_types_pkg::buf_wr_t     i_wr [`BUF_COUNT],
	input  logic [`BUF_COUNT-1:0]      i_rd,
	input  buf_types_pkg::buf_rd_rsp_t i_rsp [`BUF_COUNT],
	input  buf_types_pkg::reg_req_t    i_reg,
	input  buf_types_pkg::reg_data_t   i_reg_rdata,
	input  buf_types_pkg::reg_data_t   i_reg_exp,
	input  logic                       i_interrupt,
	input  logic                       i_fill_warning,
	input  logic [1:0]                 i_data_available,
	input  logic                       i_pin_chk,
	input  logic [1:0]                 i_pin_sel,
	input  logic [1:0]                 i_pin_exp,
	input  logic                       i_test_end,
	input  logic [7:0]                 i_test_num,
	input  logic                       i_final,
	output int                         o_errors,
	output int                         o_pending
);

	logic [`BUF_DATA_W-1:0]   model_q [`BUF_COUNT][$];	// Words held by each buffer
	logic [`BUF_DATA_W-1:0]   due_q [`BUF_COUNT][$];	// Words owed to each read port
	string                    rsp_name [`BUF_COUNT] = '{"o_cmd_rd.data", "o_ch1_rd.data",
		"o_ch2_rd.data"};
	int                       errors = 0;
	int                       checks = 0;
	int                       tests = 0;
	int                       test_base = 0;
	int                       pending = 0;
	logic                     reg_due = 1'b0;
	buf_types_pkg::reg_data_t reg_want = '0;

	assign o_errors  = errors;
	assign o_pending = pending;

	always @(posedge i_clk) begin
		logic [`BUF_DATA_W-1:0] want;
		logic                   take_rd;
		logic                   take_wr;
		logic [1:0]             got;
		string                  pin_name;
		if (!i_rst) begin
			//////////////////////////////
			// Read data against the FIFO model

			for (int i = 0; i < `BUF_COUNT; i++) begin
				if (i_rsp[i].valid) begin
					checks++;
					if (due_q[i].size() == 0) begin
						$display("Buffer %0d returned read data that nobody asked for", i);
						errors++;
					end else begin
						want = due_q[i].pop_front();
						if (i_rsp[i].data !== want) begin
							$display("FAIL %s: got %h, expected %h", rsp_name[i], i_rsp[i].data, want);
							errors++;
						end
					end
				end
			end
			for (int i = 0; i < `BUF_COUNT; i++) begin
				take_rd = i_rd[i] && (model_q[i].size() > 0);	// Reads while empty are dropped
				take_wr = i_wr[i].wr && (model_q[i].size() < `BUF_DEPTH);
				if (take_rd) begin
					due_q[i].push_back(model_q[i].pop_front());
				end
				if (take_wr) begin
					model_q[i].push_back(i_wr[i].data);
				end
			end

			//////////////////////////////
			// Register reads and pins

			if (reg_due) begin
				checks++;
				if (i_reg_rdata !== reg_want) begin
					$display("FAIL o_reg_rdata: got %h, expected %h", i_reg_rdata, reg_want);
					errors++;
				end
			end
			reg_due  = i_reg.rd;	// Data shows up one cycle after the strobe
			reg_want = i_reg_exp;

			if (i_pin_chk) begin
				case (i_pin_sel)
					2'd0: begin
						got      = {1'b0, i_interrupt};
						pin_name = "o_interrupt";
					end
					2'd1: begin
						got      = {1'b0, i_fill_warning};
						pin_name = "o_fill_warning";
					end
					default: begin
						got      = i_data_available;
						pin_name = "o_data_available";
					end
				endcase
				checks++;
				if (got !== i_pin_exp) begin
					$display("FAIL %s: got %h, expected %h", pin_name, got, i_pin_exp);
					errors++;
				end
			end

			if (i_test_end) begin
				tests++;
				if (errors == test_base) begin
					$display("test %0d passed", i_test_num);
				end else begin
					$display("test %0d failed with %0d errors", i_test_num, errors - test_base);
				end
				test_base = errors;
			end

			if (i_final) begin
				for (int i = 0; i < `BUF_COUNT; i++) begin
					if (due_q[i].size() != 0) begin
						$display("Buffer %0d never returned %0d read words", i, due_q[i].size());
						errors++;
					end
				end
				$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			end

			pending = 0;
			for (int i = 0; i < `BUF_COUNT; i++) begin
				pending += due_q[i].size();
			end
		end
	end

endmodule

// ==== tests/buffer_assertions.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module buffer_assertions (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  buf_types_pkg::mem_req_t i_req [`BUF_COUNT],
	input  logic [`BUF_COUNT-1:0]   i_grant,
	input  logic [`BUF_COUNT-1:0]   i_rsp_valid
);

	logic [`BUF_COUNT-1:0] req_vec;
	logic [`BUF_COUNT-1:0] rd_vec;
	int                    fail_count = 0;

	always_comb begin
		for (int i = 0; i < `BUF_COUNT; i++) begin
			req_vec[i] = i_req[i].req;
			rd_vec[i]  = i_req[i].req & ~i_req[i].we;
		end
	end

	a_one_grant: assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(i_grant))
		else begin
			fail_count++;
			$error("More than one RAM grant in a cycle");
		end

	a_grant_to_req: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_grant & ~req_vec) == '0)
		else begin
			fail_count++;
			$error("RAM grant to a buffer without a request");
		end

	// A response belongs to the read granted one cycle earlier
	a_rsp_after_read: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_rsp_valid & ~$past(i_grant & rd_vec)) == '0)
		else begin
			fail_count++;
			$error("Read response without a granted read");
		end

endmodule

bind ram_arbiter buffer_assertions u_buffer_assertions (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_req       (i_req),
	.i_grant     (o_grant),
	.i_rsp_valid (o_rsp_valid)
);

// ==== rtl/buffer_subsystem.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module buffer_subsystem (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  buf_types_pkg::buf_wr_t     i_cmd_wr,
	input  buf_types_pkg::buf_wr_t     i_ch1_wr,
	input  buf_types_pkg::buf_wr_t     i_ch2_wr,
	input  logic                       i_cmd_rd,
	input  logic                       i_ch1_rd,
	input  logic                       i_ch2_rd,
	output buf_types_pkg::buf_rd_rsp_t o_cmd_rd,
	output buf_types_pkg::buf_rd_rsp_t o_ch1_rd,
	output buf_types_pkg::buf_rd_rsp_t o_ch2_rd,
	input  buf_types_pkg::reg_req_t    i_reg,
	output buf_types_pkg::reg_data_t   o_reg_rdata,
	output logic                       o_interrupt,
	output logic                       o_fill_warning,
	output logic [1:0]                 o_data_available
);

	localparam int RAM_AW = `BUF_RAM_AW;
	localparam logic [`BUF_COUNT-1:0] READ_PRIO = 'b110;	// Sensor data is read first

	buf_types_pkg::buf_wr_t     wr_in   [`BUF_COUNT];
	buf_types_pkg::buf_rd_rsp_t rd_out  [`BUF_COUNT];
	buf_types_pkg::buf_status_t status  [`BUF_COUNT];
	buf_types_pkg::mem_req_t    buf_req [`BUF_COUNT];
	buf_types_pkg::mem_req_t    ram_req;
	buf_types_pkg::mem_rsp_t    ram_rsp;
	logic [`BUF_COUNT-1:0]      rd_in;
	logic [`BUF_COUNT-1:0]      grant;
	logic [`BUF_COUNT-1:0]      rsp_valid;
	logic [`BUF_COUNT-1:0]      warn_vec;

	// Buffer 0 holds host commands, 1 and 2 the sensor channels
	assign wr_in[0] = i_cmd_wr;
	assign wr_in[1] = i_ch1_wr;
	assign wr_in[2] = i_ch2_wr;
	assign rd_in    = {i_ch2_rd, i_ch1_rd, i_cmd_rd};
	assign o_cmd_rd = rd_out[0];
	assign o_ch1_rd = rd_out[1];
	assign o_ch2_rd = rd_out[2];

	//////////////////////////////
	// Buffers sharing one RAM

	for (genvar i = 0; i < `BUF_COUNT; i++) begin : g_buf
		ring_buffer #(
			.BASE        (RAM_AW'(i * `BUF_DEPTH))
		) u_ring_buffer (
			.i_clk       (i_clk),
			.i_rst       (i_rst),
			.i_wr        (wr_in[i]),
			.i_rd        (rd_in[i]),
			.o_rd        (rd_out[i]),
			.o_status    (status[i]),
			.o_mem_req   (buf_req[i]),
			.i_grant     (grant[i]),
			.i_mem_rsp   (ram_rsp),
			.i_rsp_valid (rsp_valid[i])
		);

		assign warn_vec[i] = status[i].nearly_full;
	end

	ram_arbiter u_ram_arbiter (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_req       (buf_req),
		.i_read_prio (READ_PRIO),
		.o_grant     (grant),
		.o_mem_req   (ram_req),
		.o_rsp_valid (rsp_valid)
	);

	shared_ram u_shared_ram (
		.i_clk (i_clk),
		.i_req (ram_req),
		.o_rsp (ram_rsp)
	);

	buffer_irq_regs u_buffer_irq_regs (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_reg       (i_reg),
		.o_reg_rdata (o_reg_rdata),
		.i_status    (status),
		.o_interrupt (o_interrupt)
	);

	//////////////////////////////
	// Output pins are registered so the pads never see a glitch

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_fill_warning   <= 1'b0;
			o_data_available <= '0;
		end else begin
			o_fill_warning   <= |warn_vec;
			o_data_available <= {~status[2].empty, ~status[1].empty};
		end
	end

endmodule

// ==== rtl/buffer_irq_regs.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module buffer_irq_regs (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  buf_types_pkg::reg_req_t    i_reg,
	output buf_types_pkg::reg_data_t   o_reg_rdata,
	input  buf_types_pkg::buf_status_t i_status [`BUF_COUNT],
	output logic                       o_interrupt
);

	logic [`BUF_COUNT-1:0]    irq_stat;
	logic [`BUF_COUNT-1:0]    irq_mask;
	logic [`BUF_COUNT-1:0]    full_vec;
	logic [`BUF_COUNT-1:0]    warn_vec;
	logic [`BUF_COUNT-1:0]    stat_clr;
	logic                     stat_wr;
	logic                     mask_wr;
	buf_types_pkg::reg_data_t rdata_next;

	assign full_vec[buf_regs_pkg::CMD_FULL] = i_status[0].full;
	assign full_vec[buf_regs_pkg::CH1_FULL] = i_status[1].full;
	assign full_vec[buf_regs_pkg::CH2_FULL] = i_status[2].full;

	always_comb begin
		for (int i = 0; i < `BUF_COUNT; i++) begin
			warn_vec[i] = i_status[i].nearly_full;
		end
	end

	assign stat_wr  = i_reg.wr && (i_reg.addr == buf_regs_pkg::IRQ_STAT);
	assign mask_wr  = i_reg.wr && (i_reg.addr == buf_regs_pkg::IRQ_MASK);
	assign stat_clr = stat_wr ? i_reg.wdata[`BUF_COUNT-1:0] : '0;

	//////////////////////////////
	// Interrupt status and mask

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			irq_stat    <= '0;
			irq_mask    <= '0;
			o_interrupt <= 1'b0;
		end else begin
			irq_stat <= (irq_stat & ~stat_clr) | full_vec;	// Full wins over a clear
			if (mask_wr) begin
				irq_mask <= i_reg.wdata[`BUF_COUNT-1:0];
			end
			o_interrupt <= |(irq_stat & irq_mask);
		end
	end

	//////////////////////////////
	// Read back

	always_comb begin
		case (i_reg.addr)
			buf_regs_pkg::IRQ_STAT:  rdata_next = buf_types_pkg::reg_data_t'(irq_stat);
			buf_regs_pkg::IRQ_MASK:  rdata_next = buf_types_pkg::reg_data_t'(irq_mask);
			buf_regs_pkg::FILL_WARN: rdata_next = buf_types_pkg::reg_data_t'(warn_vec);
			buf_regs_pkg::COUNT0:    rdata_next = buf_types_pkg::reg_data_t'(i_status[0].count);
			buf_regs_pkg::COUNT1:    rdata_next = buf_types_pkg::reg_data_t'(i_status[1].count);
			buf_regs_pkg::COUNT2:    rdata_next = buf_types_pkg::reg_data_t'(i_status[2].count);
			default:                 rdata_next = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		o_reg_rdata <= i_reg.rd ? rdata_next : '0;	// Zero between reads keeps the bus OR-able
	end

endmodule

// ==== rtl/shared_ram.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module shared_ram (
	input  logic                    i_clk,
	input  buf_types_pkg::mem_req_t i_req,
	output buf_types_pkg::mem_rsp_t o_rsp
);

	logic [`BUF_DATA_W-1:0] mem [`BUF_RAM_WORDS];

	always_ff @(posedge i_clk) begin
		if (i_req.req && i_req.we) begin
			mem[i_req.addr] <= i_req.wdata;
		end
		if (i_req.req && !i_req.we) begin
			o_rsp.rdata <= mem[i_req.addr];	// Holds until the next read
		end
	end

endmodule

// ==== rtl/ram_arbiter.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module ram_arbiter (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  buf_types_pkg::mem_req_t i_req [`BUF_COUNT],
	input  logic [`BUF_COUNT-1:0]   i_read_prio,
	output logic [`BUF_COUNT-1:0]   o_grant,
	output buf_types_pkg::mem_req_t o_mem_req,
	output logic [`BUF_COUNT-1:0]   o_rsp_valid
);

	logic [`BUF_COUNT-1:0] rd_req;
	logic [`BUF_COUNT-1:0] wr_req;

	always_comb begin
		for (int i = 0; i < `BUF_COUNT; i++) begin
			rd_req[i] = i_req[i].req & ~i_req[i].we;
			wr_req[i] = i_req[i].req & i_req[i].we;
		end
	end

	//////////////////////////////
	// Priority reads win over other reads, and any read wins over a write

	always_comb begin
		logic found;
		found   = 1'b0;
		o_grant = '0;
		for (int i = 0; i < `BUF_COUNT; i++) begin
			if (!found && rd_req[i] && i_read_prio[i]) begin
				o_grant[i] = 1'b1;
				found      = 1'b1;
			end
		end
		for (int i = 0; i < `BUF_COUNT; i++) begin
			if (!found && rd_req[i] && !i_read_prio[i]) begin
				o_grant[i] = 1'b1;
				found      = 1'b1;
			end
		end
		for (int i = 0; i < `BUF_COUNT; i++) begin
			if (!found && wr_req[i]) begin
				o_grant[i] = 1'b1;
				found      = 1'b1;
			end
		end
	end

	always_comb begin
		o_mem_req = '0;
		for (int i = 0; i < `BUF_COUNT; i++) begin
			if (o_grant[i]) begin
				o_mem_req = i_req[i];
			end
		end
	end

	//////////////////////////////
	// Read grant delayed to line up with the RAM output register

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_rsp_valid <= '0;
		end else begin
			o_rsp_valid <= o_grant & rd_req;
		end
	end

endmodule

// ==== rtl/ring_buffer.sv ====
`timescale 1ns/1ps
`include "buf_params.svh"

module ring_buffer #(
	parameter logic [`BUF_RAM_AW-1:0] BASE = '0
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  buf_types_pkg::buf_wr_t     i_wr,
	input  logic                       i_rd,
	output buf_types_pkg::buf_rd_rsp_t o_rd,
	output buf_types_pkg::buf_status_t o_status,
	output buf_types_pkg::mem_req_t    o_mem_req,
	input  logic                       i_grant,
	input  buf_types_pkg::mem_rsp_t    i_mem_rsp,
	input  logic                       i_rsp_valid
);

	localparam int PTR_W = $clog2(`BUF_DEPTH);
	localparam int AW    = `BUF_RAM_AW;
	localparam int CNT_W = `BUF_CNT_W;

	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W-1:0]       wr_slot;
	logic [PTR_W-1:0]       rd_slot;
	logic [`BUF_DATA_W-1:0] wr_data;
	logic                   wr_pend;
	logic                   rd_pend;
	logic                   rd_wait_wr;
	logic [CNT_W-1:0]       count;
	logic                   full;
	logic                   empty;
	logic                   rd_first;
	logic                   wr_done;
	logic                   rd_done;
	logic                   wr_acc;
	logic                   rd_acc;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(`BUF_DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign full  = (count == CNT_W'(`BUF_DEPTH));
	assign empty = (count == '0);

	// A read may target the word that still sits in the write slot
	assign rd_first = rd_pend & ~rd_wait_wr;
	assign wr_done  = i_grant & o_mem_req.we;
	assign rd_done  = i_grant & rd_first;

	// The slot frees in the same cycle it is granted, so uncontended strobes run back to back
	assign wr_acc = i_wr.wr & ~full & (~wr_pend | wr_done);
	assign rd_acc = i_rd & ~empty & (~rd_pend | rd_done);

	//////////////////////////////
	// Pointers, count and pending operations

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			wr_pend    <= 1'b0;
			rd_pend    <= 1'b0;
			rd_wait_wr <= 1'b0;
		end else begin
			if (wr_acc) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_acc) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(wr_acc) - CNT_W'(rd_acc);

			if (wr_acc) begin
				wr_pend <= 1'b1;
			end else if (wr_done) begin
				wr_pend <= 1'b0;
			end

			if (rd_acc) begin
				rd_pend <= 1'b1;
			end else if (rd_done) begin
				rd_pend <= 1'b0;
			end

			// Only an older write to the same entry holds the read back
			if (rd_acc) begin
				rd_wait_wr <= wr_pend & ~wr_done & (wr_slot == rd_ptr);
			end else if (wr_done) begin
				rd_wait_wr <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_acc) begin
			wr_slot <= wr_ptr;
			wr_data <= i_wr.data;
		end
		if (rd_acc) begin
			rd_slot <= rd_ptr;
		end
	end

	//////////////////////////////
	// One RAM request per cycle

	always_comb begin
		o_mem_req.req   = wr_pend | rd_pend;
		o_mem_req.we    = wr_pend & ~rd_first;
		o_mem_req.addr  = BASE + AW'(rd_first ? rd_slot : wr_slot);
		o_mem_req.wdata = wr_data;
	end

	assign o_rd.valid = i_rsp_valid;	// Arbiter raises this only for our own read
	assign o_rd.data  = i_mem_rsp.rdata;

	assign o_status.full        = full;
	assign o_status.nearly_full = (count >= CNT_W'(`BUF_WARN_LEVEL));
	assign o_status.empty       = empty;
	assign o_status.count       = count;

endmodule

// ==== rtl/buf_regs_pkg.sv ====
`include "buf_params.svh"

package buf_regs_pkg;

	// Register map of the buffer block
	typedef enum logic [`REG_ADDR_W-1:0] {
		IRQ_STAT  = 4'd0,	// Sticky full flags that clear on a write of 1
		IRQ_MASK  = 4'd1,
		FILL_WARN = 4'd2,	// Read only
		COUNT0    = 4'd4,
		COUNT1    = 4'd5,
		COUNT2    = 4'd6
	} reg_addr_e;

	// Bit positions in IRQ_STAT and IRQ_MASK
	typedef enum logic [1:0] {
		CMD_FULL = 2'd0,
		CH1_FULL = 2'd1,
		CH2_FULL = 2'd2
	} irq_bit_e;

endpackage

// ==== rtl/buf_types_pkg.sv ====
`include "buf_params.svh"

package buf_types_pkg;

	typedef logic [15:0] reg_data_t;

	//////////////////////////////
	// Buffer ports

	typedef struct packed {
		logic                   wr;
		logic [`BUF_DATA_W-1:0] data;
	} buf_wr_t;

	typedef struct packed {
		logic                   valid;
		logic [`BUF_DATA_W-1:0] data;
	} buf_rd_rsp_t;

	typedef struct packed {
		logic                  full;
		logic                  nearly_full;
		logic                  empty;
		logic [`BUF_CNT_W-1:0] count;
	} buf_status_t;

	//////////////////////////////
	// Shared RAM port

	typedef struct packed {
		logic                   req;
		logic                   we;
		logic [`BUF_RAM_AW-1:0] addr;
		logic [`BUF_DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [`BUF_DATA_W-1:0] rdata;
	} mem_rsp_t;

	//////////////////////////////
	// Register bus

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] addr;
		reg_data_t              wdata;
		logic                   wr;
		logic                   rd;
	} reg_req_t;

endpackage

// ==== rtl/buf_params.svh ====
`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

//////////////////////////////
// Buffer geometry

`define BUF_COUNT 3
`define BUF_DEPTH 8
`define BUF_DATA_W 16

// Count at which nearly_full rises
`define BUF_WARN_LEVEL 6

// Count needs one more bit than the pointers to hold BUF_DEPTH itself
`define BUF_CNT_W $clog2(`BUF_DEPTH + 1)

//////////////////////////////
// Shared RAM with one region of BUF_DEPTH words per buffer

`define BUF_RAM_WORDS (`BUF_COUNT * `BUF_DEPTH)
`define BUF_RAM_AW $clog2(`BUF_RAM_WORDS)

//////////////////////////////
// Register bus

`define REG_ADDR_W 4

`endif
